// ==== source/FrontEndPkg.sv ====
//##########################################################
// Front-end package
// Queue sizing, fetch and decode widths, opcode classes
// and the decoded packet carried through the buffer
//##########################################################
`default_nettype none

package FrontEndPkg;

  // Widths of the fetch, decode and dispatch paths
  localparam int FETCH_WIDTH    = 4;
  localparam int DECODE_SLOTS   = 2 * FETCH_WIDTH;  // Every lane may split in two
  localparam int DISPATCH_WIDTH = 4;

  // Instruction buffer sizing
  localparam int INST_QUEUE     = 32;
  localparam int INST_QUEUE_LOG = 5;
  localparam int STALL_LIMIT    = INST_QUEUE - DECODE_SLOTS;  // Room for one full group

  // Field widths
  localparam int OPCODE_W = 8;
  localparam int IMM_W    = 16;
  localparam int PC_W     = 32;

  // Opcode class sits in the two top opcode bits
  localparam logic [1:0] OPC_CLASS_SPLIT  = 2'd2;  // Two micro-ops
  localparam logic [1:0] OPC_CLASS_BRANCH = 2'd3;  // Marks isBranch

  // One micro-op as stored in the buffer, 58 bits
  typedef struct packed {
    logic [PC_W-1:0]     pc;
    logic [OPCODE_W-1:0] opcode;
    logic [IMM_W-1:0]    immediate;
    logic                uopIdx;    // 0 first, 1 second half of a split
    logic                isBranch;
  } decodedPacket_t;

  // Raw instruction from fetch, 24 bits
  typedef struct packed {
    logic [OPCODE_W-1:0] opcode;
    logic [IMM_W-1:0]    immediate;
  } fetchInst_t;

endpackage

`default_nettype wire

// ==== source/MultiPortRam.sv ====
//##########################################################
// Multi-port packet storage
// Register array with 4 async read and 8 clocked write ports
//##########################################################
`timescale 1ns/1ps
`default_nettype none

module MultiPortRam import FrontEndPkg::*; (
  input  wire                       clk,
  input  wire                       rstN_i,

  // Read side, head of queue
  input  wire  [INST_QUEUE_LOG-1:0] readAddr_i [DISPATCH_WIDTH],
  output decodedPacket_t            readData_o [DISPATCH_WIDTH],

  // Write side, tail of queue
  input  wire  [DECODE_SLOTS-1:0]   writeEn_i,
  input  wire  [INST_QUEUE_LOG-1:0] writeAddr_i [DECODE_SLOTS],
  input  decodedPacket_t            writeData_i [DECODE_SLOTS]
);

  decodedPacket_t mem [INST_QUEUE];  // Storage array

  //##########################################################
  // Read ports
  //##########################################################
  always_comb begin
    for (int r = 0; r < DISPATCH_WIDTH; r++) begin
      readData_o[r] = mem[readAddr_i[r]];  // No read latency
    end
  end

  //##########################################################
  // Write ports
  //##########################################################
  // Caller keeps the enabled write addresses distinct
  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      mem <= '{default: '0};  // Array cleared for a known start
    end else begin
      for (int w = 0; w < DECODE_SLOTS; w++) begin
        if (writeEn_i[w]) begin
          mem[writeAddr_i[w]] <= writeData_i[w];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/DecodeSplitter.sv ====
//##########################################################
// Decode and split stage
// Splits split-class opcodes in two, marks branches and
// packs the micro-ops into contiguous registered slots
//##########################################################
`timescale 1ns/1ps
`default_nettype none

module DecodeSplitter import FrontEndPkg::*; (
  input  wire                     clk,
  input  wire                     rstN_i,
  input  wire                     flush_i,

  // Fetch group in
  input  wire                     fetchValid_i,
  input  wire  [FETCH_WIDTH-1:0]  fetchVector_i,  // Lanes may be sparse
  input  wire  [PC_W-1:0]         fetchPc_i,      // PC of lane 0
  input  fetchInst_t              fetchInst_i [FETCH_WIDTH],
  output logic                    fetchReady_o,

  // Packets out to the buffer
  input  wire                     bufAccept_i,
  output logic                    decodeValid_o,
  output logic [DECODE_SLOTS-1:0] decodeVector_o,  // Contiguous from slot 0
  output decodedPacket_t          decodePacket_o [DECODE_SLOTS]
);

  logic [DECODE_SLOTS-1:0] nextVector;
  decodedPacket_t          nextPacket [DECODE_SLOTS];

  //##########################################################
  // Split and compact
  //##########################################################
  always_comb begin : splitLanes
    logic [3:0]     slot;      // Next free output slot
    logic [1:0]     opcClass;
    decodedPacket_t pkt;

    slot       = '0;
    pkt        = '0;
    nextVector = '0;
    nextPacket = '{default: '0};
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      opcClass = fetchInst_i[k].opcode[OPCODE_W-1 -: 2];
      if (fetchVector_i[k]) begin
        // First (or only) micro-op of this lane
        pkt.pc        = fetchPc_i + PC_W'(4 * k);
        pkt.opcode    = fetchInst_i[k].opcode;
        pkt.immediate = fetchInst_i[k].immediate;
        pkt.uopIdx    = 1'b0;
        pkt.isBranch  = (opcClass == OPC_CLASS_BRANCH);
        nextPacket[slot[2:0]] = pkt;
        nextVector[slot[2:0]] = 1'b1;
        slot = slot + 4'd1;
        if (opcClass == OPC_CLASS_SPLIT) begin
          pkt.uopIdx = 1'b1;  // Second half, same PC
          nextPacket[slot[2:0]] = pkt;
          nextVector[slot[2:0]] = 1'b1;
          slot = slot + 4'd1;
        end
      end
    end
  end

  //##########################################################
  // Decode register
  //##########################################################
  // Free when empty or draining into the buffer this edge
  assign fetchReady_o = ~decodeValid_o | bufAccept_i;

  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      decodeValid_o <= 1'b0;
    end else if (flush_i) begin
      decodeValid_o <= 1'b0;  // Drop whatever is held
    end else if (fetchReady_o) begin
      decodeValid_o <= fetchValid_i;
    end
  end

  // Payload only, qualified by decodeValid_o
  always_ff @(posedge clk) begin
    if (fetchReady_o && fetchValid_i) begin
      decodeVector_o <= nextVector;
      decodePacket_o <= nextPacket;
    end
  end

endmodule

`default_nettype wire

// ==== source/InstructionBuffer.sv ====
//##########################################################
// Instruction buffer
// Circular queue between decode and dispatch, eight writes
// in and four packets out per transfer
//##########################################################
`timescale 1ns/1ps
`default_nettype none

module InstructionBuffer import FrontEndPkg::*; (
  input  wire                     clk,
  input  wire                     rstN_i,
  input  wire                     flush_i,

  // From decode
  input  wire                     decodeValid_i,
  input  wire  [DECODE_SLOTS-1:0] decodeVector_i,
  input  decodedPacket_t          decodePacket_i [DECODE_SLOTS],
  output logic                    bufAccept_o,

  // To dispatch
  input  wire                     dispatchReady_i,
  output logic                    dispatchValid_o,
  output decodedPacket_t          dispatchPacket_o [DISPATCH_WIDTH],  // Oldest first
  output logic [2:0]              branchCount_o
);

  // Queue state
  logic [INST_QUEUE_LOG-1:0] headPtr;
  logic [INST_QUEUE_LOG-1:0] tailPtr;
  logic [INST_QUEUE_LOG:0]   instCount;  // 0 to INST_QUEUE

  logic [INST_QUEUE_LOG-1:0] readAddr  [DISPATCH_WIDTH];
  logic [INST_QUEUE_LOG-1:0] writeAddr [DECODE_SLOTS];
  logic [DECODE_SLOTS-1:0]   writeEn;
  logic [3:0]                writeCount;  // Slots written this edge
  logic                      writeFire;
  logic                      dispatchFire;

  MultiPortRam ram (
    .clk         (clk),
    .rstN_i      (rstN_i),
    .readAddr_i  (readAddr),
    .readData_o  (dispatchPacket_o),
    .writeEn_i   (writeEn),
    .writeAddr_i (writeAddr),
    .writeData_i (decodePacket_i)
  );

  //##########################################################
  // Handshakes
  //##########################################################
  assign bufAccept_o     = (instCount <= STALL_LIMIT);  // Space for a full group
  assign dispatchValid_o = (instCount >= DISPATCH_WIDTH);
  assign writeFire       = decodeValid_i & bufAccept_o & ~flush_i;
  assign dispatchFire    = dispatchValid_o & dispatchReady_i;

  //##########################################################
  // Address generation
  //##########################################################
  always_comb begin
    for (int k = 0; k < DECODE_SLOTS; k++) begin
      writeAddr[k] = tailPtr + INST_QUEUE_LOG'(k);  // Wraps at INST_QUEUE
      writeEn[k]   = writeFire & decodeVector_i[k];
    end
    for (int r = 0; r < DISPATCH_WIDTH; r++) begin
      readAddr[r] = headPtr + INST_QUEUE_LOG'(r);
    end
  end

  // Vector is contiguous so a popcount gives the tail step
  always_comb begin
    writeCount = '0;
    for (int k = 0; k < DECODE_SLOTS; k++) begin
      writeCount = writeCount + {3'b0, writeEn[k]};
    end
  end

  // Branches in the dispatch window
  always_comb begin
    branchCount_o = '0;
    for (int r = 0; r < DISPATCH_WIDTH; r++) begin
      branchCount_o = branchCount_o + {2'b0, dispatchPacket_o[r].isBranch};
    end
  end

  //##########################################################
  // Pointer and count update
  //##########################################################
  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      headPtr   <= '0;
      tailPtr   <= '0;
      instCount <= '0;
    end else if (flush_i) begin
      headPtr   <= '0;  // Queue emptied in one edge
      tailPtr   <= '0;
      instCount <= '0;
    end else begin
      tailPtr <= tailPtr + INST_QUEUE_LOG'(writeCount);
      if (dispatchFire) begin
        headPtr <= headPtr + INST_QUEUE_LOG'(DISPATCH_WIDTH);
      end
      // Writes in and dispatch out in one step
      instCount <= instCount + (INST_QUEUE_LOG + 1)'(writeCount)
                 - (dispatchFire ? (INST_QUEUE_LOG + 1)'(DISPATCH_WIDTH) : '0);
    end
  end

endmodule

`default_nettype wire

// ==== source/FrontEndTop.sv ====
//##########################################################
// Front-end decoupling top
// Decode stage feeding the instruction buffer
//##########################################################
`timescale 1ns/1ps
`default_nettype none

module FrontEndTop import FrontEndPkg::*; (
  input  wire                    clk,
  input  wire                    rstN_i,
  input  wire                    flush_i,

  // Fetch side
  input  wire                    fetchValid_i,
  input  wire  [FETCH_WIDTH-1:0] fetchVector_i,
  input  wire  [PC_W-1:0]        fetchPc_i,
  input  fetchInst_t             fetchInst_i [FETCH_WIDTH],
  output logic                   fetchReady_o,

  // Dispatch side
  input  wire                    dispatchReady_i,
  output logic                   dispatchValid_o,
  output decodedPacket_t         dispatchPacket_o [DISPATCH_WIDTH],
  output logic [2:0]             branchCount_o
);

  // Decode register to buffer
  logic                    decodeValid;
  logic [DECODE_SLOTS-1:0] decodeVector;
  decodedPacket_t          decodePacket [DECODE_SLOTS];
  logic                    bufAccept;  // Low while the buffer is near full

  DecodeSplitter decode (
    .clk            (clk),
    .rstN_i         (rstN_i),
    .flush_i        (flush_i),
    .fetchValid_i   (fetchValid_i),
    .fetchVector_i  (fetchVector_i),
    .fetchPc_i      (fetchPc_i),
    .fetchInst_i    (fetchInst_i),
    .fetchReady_o   (fetchReady_o),
    .bufAccept_i    (bufAccept),
    .decodeValid_o  (decodeValid),
    .decodeVector_o (decodeVector),
    .decodePacket_o (decodePacket)
  );

  InstructionBuffer instBuf (
    .clk              (clk),
    .rstN_i           (rstN_i),
    .flush_i          (flush_i),
    .decodeValid_i    (decodeValid),
    .decodeVector_i   (decodeVector),
    .decodePacket_i   (decodePacket),
    .bufAccept_o      (bufAccept),
    .dispatchReady_i  (dispatchReady_i),
    .dispatchValid_o  (dispatchValid_o),
    .dispatchPacket_o (dispatchPacket_o),
    .branchCount_o    (branchCount_o)
  );

endmodule

`default_nettype wire

// ==== sim/InstructionBufferAsserts.sv ====
//##########################################################
// Instruction buffer assertions
// Occupancy bounds and the accept and dispatch handshakes
//##########################################################
`timescale 1ns/1ps
`default_nettype none

module InstructionBufferAsserts import FrontEndPkg::*; (
  input wire                    clk,
  input wire                    rstN_i,
  input wire                    flush_i,
  input wire [INST_QUEUE_LOG:0] instCount_i,
  input wire                    dispatchValid_i,
  input wire                    dispatchReady_i
);

  // Never more packets than storage slots
  countBound: assert property (@(posedge clk) disable iff (!rstN_i)
    instCount_i <= (INST_QUEUE_LOG + 1)'(INST_QUEUE))
    else $error("Buffer count above queue depth");

  // Near full means no more writes, count can only fall
  acceptStall: assert property (@(posedge clk) disable iff (!rstN_i)
    (instCount_i > (INST_QUEUE_LOG + 1)'(STALL_LIMIT))
      |=> (instCount_i <= $past(instCount_i)))
    else $error("Buffer took a write above the stall limit");

  // Count drops only on a dispatch transfer or a flush
  dispatchHold: assert property (@(posedge clk) disable iff (!rstN_i)
    (!(dispatchValid_i && dispatchReady_i) && !flush_i)
      |=> (instCount_i >= $past(instCount_i)))
    else $error("Buffer lost packets without a dispatch transfer");

endmodule

bind InstructionBuffer InstructionBufferAsserts bufAsserts (
  .clk             (clk),
  .rstN_i          (rstN_i),
  .flush_i         (flush_i),
  .instCount_i     (instCount),
  .dispatchValid_i (dispatchValid_o),
  .dispatchReady_i (dispatchReady_i)
);

`default_nettype wire

// ==== sim/FrontEndTb.sv ====
//##########################################################
// Front-end testbench
// Random fixed-seed fetch and dispatch traffic, checked
// against a packet queue model
//##########################################################
`timescale 1ns/1ps
`default_nettype none

module FrontEndTb import FrontEndPkg::*; ();

  localparam int CLK_PERIOD  = 8;
  localparam int DRAIN_LIMIT = 40;
  // Traffic of all tests plus five worst-case drains
  localparam int TOTAL_CYCLES = 4 + 300 + 200 + 40 + 100 + 60 + 62 + 200
                              + 5 * (2 * DRAIN_LIMIT + 7);

  logic                   clk = 1'b0;
  logic                   rstN;
  logic                   flush;
  logic                   fetchValid;
  logic [FETCH_WIDTH-1:0] fetchVector;
  logic [PC_W-1:0]        fetchPc;
  fetchInst_t             fetchInst [FETCH_WIDTH];
  logic                   fetchReady;
  logic                   dispatchReady;
  logic                   dispatchValid;
  decodedPacket_t         dispatchPacket [DISPATCH_WIDTH];
  logic [2:0]             branchCount;

  decodedPacket_t  modelQ [$];            // Expected packets, oldest first
  logic [31:0]     lcgState = 32'd60239;  // Fixed seed
  logic [PC_W-1:0] pcBase;
  bit              fetchTaken;            // Group goes in at the coming edge
  bit              flushSeen;
  bit              stallSeen;
  int              modelSizeSampled;
  int              errorCount;
  int              checkCount;
  int              testErrors;
  int              testCount;

  FrontEndTop UUT (
    .clk              (clk),
    .rstN_i           (rstN),
    .flush_i          (flush),
    .fetchValid_i     (fetchValid),
    .fetchVector_i    (fetchVector),
    .fetchPc_i        (fetchPc),
    .fetchInst_i      (fetchInst),
    .fetchReady_o     (fetchReady),
    .dispatchReady_i  (dispatchReady),
    .dispatchValid_o  (dispatchValid),
    .dispatchPacket_o (dispatchPacket),
    .branchCount_o    (branchCount)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Watchdog, twice the longest expected run
  initial begin
    #(TOTAL_CYCLES * CLK_PERIOD * 2);
    $display("Timeout: run did not finish within %0d cycles", 2 * TOTAL_CYCLES);
    $display("Test failures found");
    $finish;
  end

  //##########################################################
  // Random source and checking
  //##########################################################
  function automatic logic [15:0] nextRand();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState[31:16];  // Upper half, longer period
  endfunction

  function automatic int randBelow(input int n);
    return int'(nextRand()) % n;
  endfunction

  task automatic checkValue(input logic [63:0] actual, input logic [63:0] expected,
                            input string what);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      testErrors++;
      $display("error at %0t ns: %s, got %0h expected %0h", $time, what, actual, expected);
    end
  endtask

  //##########################################################
  // Stimulus and model
  //##########################################################
  task automatic loadGroup();
    logic [15:0] r;
    r           = nextRand();
    fetchValid  = 1'b1;
    fetchVector = r[3:0];  // Sparse lanes allowed
    fetchPc     = pcBase;
    pcBase      = pcBase + 32'd16;
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      r = nextRand();
      fetchInst[k].opcode    = r[7:0];  // Class in top two bits
      fetchInst[k].immediate = nextRand();
    end
  endtask

  // Split class gives two micro-ops, branch class sets the flag
  task automatic expandGroup();
    decodedPacket_t pkt;
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      if (fetchVector[k]) begin
        pkt.pc        = fetchPc + PC_W'(4 * k);
        pkt.opcode    = fetchInst[k].opcode;
        pkt.immediate = fetchInst[k].immediate;
        pkt.uopIdx    = 1'b0;
        pkt.isBranch  = (fetchInst[k].opcode[7:6] == OPC_CLASS_BRANCH);
        modelQ.push_back(pkt);
        if (fetchInst[k].opcode[7:6] == OPC_CLASS_SPLIT) begin
          pkt.uopIdx = 1'b1;  // Same PC
          modelQ.push_back(pkt);
        end
      end
    end
  endtask

  task automatic compareDispatch();
    decodedPacket_t expected;
    int             branches;
    branches = 0;
    if (modelQ.size() < DISPATCH_WIDTH) begin
      errorCount++;
      testErrors++;
      $display("Dispatch at %0t ns with only %0d packets expected", $time, modelQ.size());
    end else begin
      for (int r = 0; r < DISPATCH_WIDTH; r++) begin
        expected = modelQ.pop_front();
        checkValue(64'(dispatchPacket[r]), 64'(expected), $sformatf("dispatch lane %0d", r));
        branches += int'(expected.isBranch);
      end
      checkValue(64'(branchCount), 64'(branches), "branch count");
    end
  endtask

  // Inputs and outputs are settled here, ahead of the rising edge
  task automatic sampleEdge();
    if (flushSeen) begin
      checkValue(64'(dispatchValid), 64'(0), "dispatchValid after flush");
      checkValue(64'(fetchReady), 64'(1), "fetchReady after flush");
    end
    flushSeen        = flush;
    modelSizeSampled = modelQ.size();
    fetchTaken       = fetchValid & fetchReady;
    if (!fetchReady) stallSeen = 1'b1;
    if (flush) begin
      modelQ.delete();  // Decode register and buffer both emptied
    end else begin
      if (dispatchValid && dispatchReady) compareDispatch();
      if (fetchTaken) expandGroup();
    end
  endtask

  task automatic runCycle(input bit allowFetch, input int readyPct, input int flushPct);
    @(negedge clk);
    if (!fetchValid || fetchTaken) begin  // Held group stays until taken
      if (allowFetch && randBelow(100) < 80) begin
        loadGroup();
      end else begin
        fetchValid = 1'b0;
      end
    end
    dispatchReady = (randBelow(100) < readyPct);
    flush         = (randBelow(100) < flushPct);
    #1;
    sampleEdge();
  endtask

  // Stop fetch, let dispatch run dry, then watch the leftovers
  task automatic drainBuffer();
    int cycles;
    cycles = 0;
    do begin
      runCycle(1'b0, 100, 0);
      cycles++;
    end while (fetchValid && !fetchTaken && cycles < DRAIN_LIMIT);
    repeat (3) runCycle(1'b0, 100, 0);
    checkValue(64'(dispatchValid), 64'(modelSizeSampled >= DISPATCH_WIDTH),
               "dispatchValid three cycles after fetch stop");
    cycles = 0;
    while (dispatchValid && cycles < DRAIN_LIMIT) begin
      runCycle(1'b0, 100, 0);
      cycles++;
    end
    if (dispatchValid) begin
      errorCount++;
      testErrors++;
      $display("Buffer kept dispatching for %0d cycles after fetch stopped", DRAIN_LIMIT);
    end
    repeat (4) begin  // Fewer than four left, nothing moves
      runCycle(1'b0, 100, 0);
      checkValue(64'(dispatchValid), 64'(modelSizeSampled >= DISPATCH_WIDTH),
                 "dispatchValid with leftovers");
    end
  endtask

  task automatic endTest(input string name);
    testCount++;
    $display("Test %0d %s: %s, %0d errors", testCount, name,
             (testErrors == 0) ? "passed" : "failed", testErrors);
    testErrors = 0;
  endtask

  //##########################################################
  // Test sequence
  //##########################################################
  initial begin
    rstN          = 1'b0;
    flush         = 1'b0;
    fetchValid    = 1'b0;
    fetchVector   = '0;
    fetchPc       = '0;
    fetchInst     = '{default: '0};
    dispatchReady = 1'b0;
    pcBase        = 32'h0000_1000;
    repeat (4) @(negedge clk);
    rstN = 1'b1;
    #1;

    checkValue(64'(dispatchValid), 64'(0), "dispatchValid out of reset");
    checkValue(64'(fetchReady), 64'(1), "fetchReady out of reset");
    endTest("reset state");

    repeat (300) runCycle(1'b1, 100, 0);  // Ready held high
    drainBuffer();
    endTest("in-order dispatch");

    repeat (200) runCycle(1'b1, 60, 0);
    drainBuffer();
    endTest("branch count");

    stallSeen = 1'b0;
    repeat (40) runCycle(1'b1, 0, 0);  // Consumer stalled
    checkValue(64'(stallSeen), 64'(1), "fetchReady fell under back-pressure");
    repeat (100) runCycle(1'b1, 100, 0);
    drainBuffer();
    endTest("back-pressure");

    repeat (60) runCycle(1'b1, 80, 0);
    drainBuffer();
    endTest("fetch stop");

    repeat (60) runCycle(1'b1, 70, 0);
    runCycle(1'b1, 70, 100);  // Forced flush
    runCycle(1'b1, 70, 0);
    repeat (200) runCycle(1'b1, 80, 2);  // Sparse random flushes
    drainBuffer();
    endTest("flush");

    $display("Summary: %0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
source/FrontEndPkg.sv
source/MultiPortRam.sv
source/DecodeSplitter.sv
source/InstructionBuffer.sv
source/FrontEndTop.sv
sim/InstructionBufferAsserts.sv
sim/FrontEndTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the front-end testbench with Verilator, run it and scan the log
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module FrontEndTb -Mdir "$BUILD_DIR" -f project.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/VFrontEndTb" | tee "$LOG_FILE"
simStatus=${PIPESTATUS[0]}
if [ "$simStatus" -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -q "Test failures found" "$LOG_FILE"; then
  echo "Simulation reported failures"
  exit 1
fi
echo "Simulation passed"
exit 0
